// File: sim.f
+incdir+tests
source/core_pkg.sv
source/unified_mem.sv
source/mem_arbiter.sv
source/reg_file.sv
source/raw_scoreboard.sv
source/fetch.sv
source/issue_queue.sv
source/execute.sv
source/core_top.sv
tests/tb_clock.sv
tests/tb_core_top.sv

// File: tests/tb_model.svh
// Program generator and instruction-level model, included inside the testbench module
// Code sits in words 0 to 127 and data in 128 to 255. r7 is the only load and store base

`ifndef tb_model_svh
`define tb_model_svh

logic [xlen_c-1:0] image [mem_words_c];      // what the host loads
logic [xlen_c-1:0] model_mem [mem_words_c];  // memory after the model ran
wb_t               exp_wb_q [$];             // writebacks in program order
int                prog_len;

function automatic int rand_range(input int lo, input int hi);
   return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

// Register form, low6 holds imm6 or rt in bits 5:3
function automatic logic [15:0] encode_reg(input opcode_e op, input int rd, input int rs,
                                           input int low6);
   return {op, 3'(rd), 3'(rs), 6'(low6)};
endfunction

// Instruction mix per mode: 0 ALU, 1 memory, 2 control flow, 3 load heavy
function automatic opcode_e pick_op(input int mode, input int roll);
   opcode_e op;
   op = op_addi;
   case (mode)
      0: if (roll >= 5) op = op_add;
      1: begin
         if (roll >= 8) op = op_st;
         else if (roll >= 5) op = op_ld;
         else if (roll >= 3) op = op_add;
      end
      2: begin
         if (roll >= 8) op = op_nop;
         else if (roll == 7) op = op_j;
         else if (roll >= 5) op = op_beqz;
         else if (roll >= 3) op = op_add;
      end
      default: begin
         if (roll == 9) op = op_addi;
         else if (roll == 8) op = op_add;
         else if (roll >= 6) op = op_st;
         else op = op_ld;
      end
   endcase
   return op;
endfunction

task automatic build_program(input int mode);
   opcode_e op;
   int      hi;
   int      rd;
   int      rs;
   int      rt;
   int      off;
   // Random background everywhere, then the program on top
   for (int a = 0; a < mem_words_c; a++) begin
      image[a] = 16'($random(seed));
   end
   prog_len = (mode == 3) ? rand_range(40, 60) : rand_range(20, 40);
   hi       = (mode == 0) ? 2 : ((mode == 2) ? 3 : 6);
   // Base r7 lands in 160..190, so base plus imm6 stays in 128..221
   image[0] = encode_reg(op_addi, 7, 7, 16);
   image[1] = encode_reg(op_add, 7, 7, 7 << 3);
   image[2] = encode_reg(op_add, 7, 7, 7 << 3);
   image[3] = encode_reg(op_add, 7, 7, 7 << 3);
   image[4] = encode_reg(op_addi, 7, 7, 31);
   image[5] = encode_reg(op_addi, 7, 7, rand_range(1, 31));
   for (int pc = 6; pc < prog_len - 1; pc++) begin
      op  = pick_op(mode, rand_range(0, 9));
      rd  = rand_range(0, hi);
      rs  = rand_range(0, hi);
      rt  = rand_range(0, hi);
      // Forward only, never past the final HALT
      off = rand_range(0, (prog_len - 2 - pc < 3) ? prog_len - 2 - pc : 3);
      case (op)
         op_addi: begin
            // Tiny immediates in mode 2 keep some registers at zero for BEQZ
            image[pc] = encode_reg(op, rd, rs,
                                   (mode == 2) ? rand_range(-1, 1) : rand_range(-32, 31));
         end
         op_add:  image[pc] = encode_reg(op, rd, rs, rt << 3);
         op_ld:   image[pc] = encode_reg(op, rd, 7, rand_range(-32, 31));
         op_st:   image[pc] = encode_reg(op, rand_range(0, 7), 7, rand_range(-32, 31));
         op_beqz: image[pc] = {op_beqz, 3'(rs), 9'(off)};
         op_j:    image[pc] = {op_j, 12'(off)};
         default: image[pc] = {op_nop, 12'(rand_range(0, 4095))};
      endcase
   end
   image[prog_len-1] = {op_halt, 12'h000};
endtask

task automatic run_model();
   logic [xlen_c-1:0] regs [8];
   logic [xlen_c-1:0] ins;
   logic [xlen_c-1:0] imm;
   logic [xlen_c-1:0] ea;
   logic [2:0]        rd;
   logic [2:0]        rs;
   logic [2:0]        rt;
   wb_t               wr;
   int                pc;
   int                next;
   int                steps;
   bit                done;
   exp_wb_q.delete();
   for (int a = 0; a < mem_words_c; a++) begin
      model_mem[a] = image[a];
   end
   for (int r = 0; r < 8; r++) begin
      regs[r] = '0;
   end
   pc    = 0;
   steps = 0;
   done  = 1'b0;
   while (!done && steps < 1000) begin
      ins  = model_mem[pc];
      rd   = ins[11:9];
      rs   = ins[8:6];
      rt   = ins[5:3];
      imm  = {{10{ins[5]}}, ins[5:0]};
      next = (pc + 1) & 255;
      wr   = '0;
      case (opcode_e'(ins[15:12]))
         op_halt: done = 1'b1;
         op_addi: wr = {1'b1, rd, 16'(regs[rs] + imm)};
         op_add:  wr = {1'b1, rd, 16'(regs[rs] + regs[rt])};
         op_ld: begin
            ea = regs[rs] + imm;
            wr = {1'b1, rd, model_mem[ea[7:0]]};
         end
         op_st: begin
            // Store data comes from the rd field
            ea = regs[rs] + imm;
            model_mem[ea[7:0]] = regs[rd];
         end
         op_beqz: begin
            // Tested register sits in 11:9
            if (regs[rd] == '0) begin
               next = (pc + 1 + int'($signed(ins[8:0]))) & 255;
            end
         end
         op_j:    next = (pc + 1 + int'($signed(ins[11:0]))) & 255;
         default: ;
      endcase
      if (wr.valid) begin
         regs[wr.rd] = wr.data;
         exp_wb_q.push_back(wr);
      end
      pc = next;
      steps++;
   end
endtask

`endif

// File: tests/tb_core_top.sv
`timescale 1ns/1ps
// Random programs on the core, each after a fresh reset, checked against a model
// Inputs change on the falling edge and outputs are sampled on it as well

module tb_core_top import core_pkg::*; ();

   localparam int clk_period_c  = 20;
   localparam int num_progs_c   = 40;
   localparam int prog_cycles_c = 5000;
   // Host load, load readback and data readback per program
   localparam int host_cycles_c = 6 * mem_words_c + 64;
   localparam int watchdog_ns_c = num_progs_c * (prog_cycles_c + host_cycles_c) * clk_period_c;

   logic              clk;
   logic              arst_n;
   logic              reset_req;
   logic              run;
   mem_req_t          host_req;
   logic              host_gnt;
   logic              host_rvalid;
   logic [xlen_c-1:0] host_rdata;
   wb_t               wb;
   logic              halted;
   integer            seed = 32'hf2c1_7d9e;

   `include "tb_model.svh"

   tb_clock #(.period_ns_p(clk_period_c), .reset_cycles_p(10)) clock_i (
      .reset_req (reset_req),
      .clk       (clk),
      .arst_n    (arst_n)
   );

   core_top #(.queue_depth_p(4), .mem_words_p(mem_words_c)) dut_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .run         (run),
      .host_req    (host_req),
      .host_gnt    (host_gnt),
      .host_rvalid (host_rvalid),
      .host_rdata  (host_rdata),
      .wb          (wb),
      .halted      (halted)
   );

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   //////////////////////////////////////////////////
   // Host port access
   //////////////////////////////////////////////////

   task automatic host_write(input int addr, input logic [xlen_c-1:0] data);
      @(negedge clk);
      host_req = '{valid: 1'b1, we: 1'b1, addr: 8'(addr), wdata: data};
      @(negedge clk);
      assert (host_gnt) else begin
         $display("Host write to word %0d was not granted at %0t", addr, $time);
         abort_run();
      end
      host_req = '0;
   endtask

   // Response is due one cycle after the grant
   task automatic host_read_check(input int addr, input logic [xlen_c-1:0] want);
      @(negedge clk);
      host_req = '{valid: 1'b1, we: 1'b0, addr: 8'(addr), wdata: '0};
      @(negedge clk);
      assert (host_gnt && host_rvalid) else begin
         $display("Host read of word %0d got no grant or no rvalid at %0t", addr, $time);
         abort_run();
      end
      assert (host_rdata == want) else begin
         $display("Error at %0t: host_rdata word %0d is %h, expected %h",
                  $time, addr, host_rdata, want);
         abort_run();
      end
      host_req = '0;
   endtask

   //////////////////////////////////////////////////
   // Writeback monitor
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      wb_t want;
      if (wb.valid) begin
         assert (!halted) else begin
            $display("Writeback to r%0d after halted at %0t", wb.rd, $time);
            abort_run();
         end
         assert (exp_wb_q.size() > 0) else begin
            $display("Unexpected writeback to r%0d at %0t", wb.rd, $time);
            abort_run();
         end
         want = exp_wb_q.pop_front();
         assert (wb.rd == want.rd) else begin
            $display("Error at %0t: wb.rd is %0d, expected %0d", $time, wb.rd, want.rd);
            abort_run();
         end
         assert (wb.data == want.data) else begin
            $display("Error at %0t: wb.data is %h, expected %h", $time, wb.data, want.data);
            abort_run();
         end
      end
   end

   //////////////////////////////////////////////////
   // Program flow
   //////////////////////////////////////////////////

   task automatic restart_core();
      @(negedge clk);
      reset_req = 1'b1;
      @(posedge arst_n);
      reset_req = 1'b0;
   endtask

   // Load the whole image, then read every word back
   task automatic load_memory();
      for (int a = 0; a < mem_words_c; a++) begin
         host_write(a, image[a]);
      end
      for (int a = 0; a < mem_words_c; a++) begin
         host_read_check(a, image[a]);
      end
   endtask

   task automatic run_program(input int p, input int mode);
      int cycles;
      int a;
      @(negedge clk);
      run    = 1'b1;
      cycles = 0;
      while (!halted && cycles < prog_cycles_c) begin
         @(negedge clk);
         cycles++;
         // Host traffic steals memory cycles from fetch and data
         if (mode == 3 && !halted && rand_range(0, 3) == 0) begin
            a = rand_range(0, prog_len - 1);
            host_read_check(a, image[a]);
            cycles += 2;
         end
      end
      assert (halted) else begin
         $display("Program %0d did not halt within %0d cycles", p, prog_cycles_c);
         abort_run();
      end
      assert (exp_wb_q.size() == 0) else begin
         $display("Program %0d halted with %0d writebacks missing", p, exp_wb_q.size());
         abort_run();
      end
      run = 1'b0;
      // Quiet period, the monitor flags any late writeback
      repeat (20) @(negedge clk);
      assert (halted) else begin
         $display("halted dropped after program %0d at %0t", p, $time);
         abort_run();
      end
   endtask

   initial begin
      reset_req = 1'b0;
      run       = 1'b0;
      host_req  = '0;
      wait (arst_n === 1'b1);
      for (int p = 0; p < num_progs_c; p++) begin
         if (p > 0) begin
            restart_core();
         end
         build_program(p % 4);
         run_model();
         load_memory();
         run_program(p, p % 4);
         // Data region must match the model's memory
         for (int a = mem_words_c / 2; a < mem_words_c; a++) begin
            host_read_check(a, model_mem[a]);
         end
      end
      $display("Regression passed");
      $finish;
   end

   // Watchdog sized from the program count
   initial begin
      #(watchdog_ns_c);
      $display("Watchdog expired after %0d ns", watchdog_ns_c);
      abort_run();
   end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps
// Free-running clock. Reset is asserted at time zero and again on each reset_req rise
// Release happens on a falling edge after reset_cycles_p rising edges

module tb_clock #(
   parameter int period_ns_p    = 20,
   parameter int reset_cycles_p = 10
) (
   input  logic reset_req,
   output logic clk,
   output logic arst_n
);

   // Clock toggles every half period
   initial begin
      clk = 1'b0;
      forever #(period_ns_p / 2) clk = ~clk;
   end

   // Reset sequence, repeated on request
   always begin
      arst_n = 1'b0;
      repeat (reset_cycles_p) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(posedge reset_req);
   end

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps
// Core with a shared memory. Host port has top priority and always wins
// run starts fetch at PC 0, halted marks the end of the program

module core_top import core_pkg::*; #(
   parameter int queue_depth_p = 4,
   parameter int mem_words_p   = mem_words_c
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  mem_req_t          host_req,
   output logic              host_gnt,
   output logic              host_rvalid,
   output logic [xlen_c-1:0] host_rdata,
   output wb_t               wb,
   output logic              halted
);

   // Memory side
   mem_req_t           mem_req;
   mem_req_t           fetch_req;
   mem_req_t           data_req;
   logic [xlen_c-1:0]  mem_rdata;
   logic               fetch_gnt;
   logic               fetch_rvalid;
   logic               data_gnt;
   logic               data_rvalid;

   // Register file and scoreboard
   logic [reg_w_c-1:0] rs_a;
   logic [reg_w_c-1:0] rs_b;
   logic [xlen_c-1:0]  rd_a;
   logic [xlen_c-1:0]  rd_b;
   logic               src_a_used;
   logic               src_b_used;
   logic               set_valid;
   logic [reg_w_c-1:0] set_reg;
   logic               hazard;

   // Queue handshake
   logic               push;
   issue_pkt_t         pkt;
   issue_pkt_t         head;
   logic               empty;
   logic               pop;
   logic               credit_ret;

   // Shared read data goes to every requester
   assign host_rdata = mem_rdata;

   unified_mem #(.mem_words_p(mem_words_p)) u_mem (
      .clk   (clk),
      .req   (mem_req),
      .rdata (mem_rdata)
   );

   mem_arbiter u_arb (
      .clk          (clk),
      .arst_n       (arst_n),
      .host_req     (host_req),
      .data_req     (data_req),
      .fetch_req    (fetch_req),
      .host_gnt     (host_gnt),
      .data_gnt     (data_gnt),
      .fetch_gnt    (fetch_gnt),
      .mem_req      (mem_req),
      .host_rvalid  (host_rvalid),
      .data_rvalid  (data_rvalid),
      .fetch_rvalid (fetch_rvalid)
   );

   reg_file u_rf (
      .clk    (clk),
      .arst_n (arst_n),
      .rs_a   (rs_a),
      .rs_b   (rs_b),
      .rd_a   (rd_a),
      .rd_b   (rd_b),
      .wb     (wb)
   );

   raw_scoreboard u_sb (
      .clk        (clk),
      .arst_n     (arst_n),
      .set_valid  (set_valid),
      .set_reg    (set_reg),
      .wb         (wb),
      .src_a      (rs_a),
      .src_b      (rs_b),
      .src_a_used (src_a_used),
      .src_b_used (src_b_used),
      .hazard     (hazard)
   );

   fetch #(.queue_depth_p(queue_depth_p)) u_fetch (
      .clk          (clk),
      .arst_n       (arst_n),
      .run          (run),
      .fetch_req    (fetch_req),
      .fetch_gnt    (fetch_gnt),
      .fetch_rvalid (fetch_rvalid),
      .rdata        (mem_rdata),
      .rs_a         (rs_a),
      .rs_b         (rs_b),
      .rd_a         (rd_a),
      .rd_b         (rd_b),
      .src_a_used   (src_a_used),
      .src_b_used   (src_b_used),
      .set_valid    (set_valid),
      .set_reg      (set_reg),
      .hazard       (hazard),
      .push         (push),
      .pkt          (pkt),
      .credit_ret   (credit_ret)
   );

   issue_queue #(.queue_depth_p(queue_depth_p)) u_iq (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (push),
      .pkt    (pkt),
      .pop    (pop),
      .head   (head),
      .empty  (empty)
   );

   execute u_ex (
      .clk         (clk),
      .arst_n      (arst_n),
      .head        (head),
      .empty       (empty),
      .pop         (pop),
      .credit_ret  (credit_ret),
      .data_req    (data_req),
      .data_gnt    (data_gnt),
      .data_rvalid (data_rvalid),
      .rdata       (mem_rdata),
      .wb          (wb),
      .halted      (halted)
   );

endmodule

// File: source/execute.sv
`timescale 1ns/1ps
// In-order execute; a load or store blocks further pops until it completes
// HALT is final until reset

module execute import core_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  issue_pkt_t        head,
   input  logic              empty,
   output logic              pop,
   output logic              credit_ret,
   output mem_req_t          data_req,
   input  logic              data_gnt,
   input  logic              data_rvalid,
   input  logic [xlen_c-1:0] rdata,
   output wb_t               wb,
   output logic              halted
);

   typedef enum logic [1:0] {ex_idle, ex_mem, ex_load, ex_halt} xstate_e;

   xstate_e             state_q;
   logic [addr_w_c-1:0] addr_q;
   logic [xlen_c-1:0]   wdata_q;
   logic                we_q;
   logic [reg_w_c-1:0]  rd_q;
   logic [xlen_c-1:0]   sum;
   logic [xlen_c-1:0]   eff_addr;
   logic                is_mem;

   // ALU and address adders
   assign sum      = head.op_a + ((head.opcode == op_add) ? head.op_b : head.imm);
   assign eff_addr = head.op_a + head.imm;
   assign is_mem   = (head.opcode == op_ld) || (head.opcode == op_st);

   // Pop only when idle; the credit goes back in the same cycle
   assign pop        = (state_q == ex_idle) && !empty;
   assign credit_ret = pop;
   assign halted     = (state_q == ex_halt);

   //////////////////////////////////////////////////
   // Writeback
   //////////////////////////////////////////////////

   always_comb begin
      wb = '0;
      if (pop && (head.opcode == op_addi || head.opcode == op_add)) begin
         wb.valid = 1'b1;
         wb.rd    = head.rd;
         wb.data  = sum;
      end else if (state_q == ex_load && data_rvalid) begin
         // Load data lands with its response
         wb.valid = 1'b1;
         wb.rd    = rd_q;
         wb.data  = rdata;
      end
   end

   // Data port, held until granted
   assign data_req.valid = (state_q == ex_mem);
   assign data_req.we    = we_q;
   assign data_req.addr  = addr_q;
   assign data_req.wdata = wdata_q;

   //////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ex_idle;
      end else begin
         case (state_q)
            ex_idle: begin
               if (pop && head.opcode == op_halt) begin
                  state_q <= ex_halt;
               end else if (pop && is_mem) begin
                  state_q <= ex_mem;
               end
            end
            ex_mem: begin
               // Store is done on grant, load waits for data
               if (data_gnt) begin
                  state_q <= we_q ? ex_idle : ex_load;
               end
            end
            ex_load: if (data_rvalid) state_q <= ex_idle;
            default: state_q <= ex_halt;
         endcase
      end
   end

   // Captured memory operation
   always_ff @(posedge clk) begin
      if (pop && is_mem) begin
         addr_q  <= eff_addr[addr_w_c-1:0];
         wdata_q <= head.op_b;
         we_q    <= (head.opcode == op_st);
         rd_q    <= head.rd;
      end
   end

endmodule

// File: source/issue_queue.sv
`timescale 1ns/1ps
// Credit flow upstream guarantees no push when full, so there is no full flag

module issue_queue import core_pkg::*; #(
   parameter int queue_depth_p = 4
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       push,
   input  issue_pkt_t pkt,
   input  logic       pop,
   output issue_pkt_t head,
   output logic       empty
);

   localparam int ptr_w_c = (queue_depth_p > 1) ? $clog2(queue_depth_p) : 1;
   localparam int cnt_w_c = $clog2(queue_depth_p + 1);

   issue_pkt_t           slots [queue_depth_p];
   logic [ptr_w_c-1:0]   wr_ptr_q;
   logic [ptr_w_c-1:0]   rd_ptr_q;
   logic [cnt_w_c-1:0]   count_q;

   // Pointers wrap at depth, which need not be a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == ptr_w_c'(queue_depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == ptr_w_c'(queue_depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + cnt_w_c'(push) - cnt_w_c'(pop);
      end
   end

   // Payload storage
   always_ff @(posedge clk) begin
      if (push) begin
         slots[wr_ptr_q] <= pkt;
      end
   end

   assign head  = slots[rd_ptr_q];
   assign empty = (count_q == '0);

endmodule

// File: source/fetch.sv
`timescale 1ns/1ps
// One fetch in flight. J and BEQZ resolve here and never enter the queue
// ADD spends one hold cycle checking its destination before its sources

module fetch import core_pkg::*; #(
   parameter int queue_depth_p = 4
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   output mem_req_t           fetch_req,
   input  logic               fetch_gnt,
   input  logic               fetch_rvalid,
   input  logic [xlen_c-1:0]  rdata,
   output logic [reg_w_c-1:0] rs_a,
   output logic [reg_w_c-1:0] rs_b,
   input  logic [xlen_c-1:0]  rd_a,
   input  logic [xlen_c-1:0]  rd_b,
   output logic               src_a_used,
   output logic               src_b_used,
   output logic               set_valid,
   output logic [reg_w_c-1:0] set_reg,
   input  logic               hazard,
   output logic               push,
   output issue_pkt_t         pkt,
   input  logic               credit_ret
);

   localparam int credit_w_c = $clog2(queue_depth_p + 1);

   typedef enum logic [2:0] {f_idle, f_req, f_wait, f_hold, f_stop} fstate_e;

   fstate_e                state_q;
   logic [addr_w_c-1:0]    pc_q;
   logic [xlen_c-1:0]      ir_q;
   logic [credit_w_c-1:0]  credit_q;
   logic                   dst_ok_q;
   opcode_e                op;
   logic [reg_w_c-1:0]     ir_rd;
   logic                   needs_credit;
   logic                   dst_check;
   logic                   can_go;
   logic                   leave;
   logic                   taken;
   logic [addr_w_c-1:0]    br_off;
   logic [addr_w_c-1:0]    next_pc;

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////

   assign op    = opcode_e'(ir_q[15:12]);
   assign ir_rd = ir_q[11:9];

   // Port b reads rd for ADDI, LD and ST
   // For ADDI and LD that guards against WAW
   always_comb begin
      rs_a       = ir_q[8:6];
      rs_b       = ir_q[5:3];
      src_a_used = 1'b0;
      src_b_used = 1'b0;
      case (op)
         op_addi, op_ld, op_st: begin
            rs_b       = ir_rd;
            src_a_used = 1'b1;
            src_b_used = 1'b1;
         end
         op_add: begin
            // First pass looks at rd only
            if (!dst_ok_q) begin
               rs_a = ir_rd;
            end
            src_a_used = 1'b1;
            src_b_used = dst_ok_q;
         end
         op_beqz: begin
            rs_a       = ir_rd;
            src_a_used = 1'b1;
         end
         default: ;
      endcase
   end

   // Queued ops need a credit
   assign needs_credit = (op == op_halt) || (op == op_addi) || (op == op_add) ||
                         (op == op_ld) || (op == op_st);
   assign dst_check    = (op == op_add) && !dst_ok_q;
   assign can_go       = !hazard && !dst_check && (!needs_credit || credit_q != '0);
   assign leave        = (state_q == f_hold) && can_go;

   // Branch target is PC plus one plus offset
   assign taken   = (op == op_j) || (op == op_beqz && rd_a == '0);
   // Offsets wrap with the 8-bit PC and only their low byte counts
   assign br_off  = ir_q[addr_w_c-1:0];
   assign next_pc = pc_q + 1'b1 + (taken ? br_off : '0);

   //////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////

   assign push      = leave && needs_credit;
   assign set_valid = push && ((op == op_addi) || (op == op_add) || (op == op_ld));
   assign set_reg   = ir_rd;

   assign pkt.opcode = op;
   assign pkt.rd     = ir_rd;
   assign pkt.op_a   = rd_a;
   assign pkt.op_b   = rd_b;
   assign pkt.imm    = {{(xlen_c-6){ir_q[5]}}, ir_q[5:0]};

   // Next request goes out in the cycle the instruction leaves
   assign fetch_req.valid = (state_q == f_req) || (leave && op != op_halt);
   assign fetch_req.we    = 1'b0;
   assign fetch_req.addr  = (state_q == f_hold) ? next_pc : pc_q;
   assign fetch_req.wdata = '0;

   //////////////////////////////////////////////////
   // State
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= f_idle;
         pc_q     <= '0;
         credit_q <= credit_w_c'(queue_depth_p);
         dst_ok_q <= 1'b0;
      end else begin
         credit_q <= credit_q + credit_w_c'(credit_ret) - credit_w_c'(push);
         case (state_q)
            f_idle: if (run) state_q <= f_req;
            f_req:  if (fetch_gnt) state_q <= f_wait;
            f_wait: if (fetch_rvalid) state_q <= f_hold;
            f_hold: begin
               // Destination seen free once stays free until the push sets it
               if (dst_check && !hazard) begin
                  dst_ok_q <= 1'b1;
               end
               if (leave) begin
                  dst_ok_q <= 1'b0;
                  if (op == op_halt) begin
                     state_q <= f_stop;
                  end else begin
                     pc_q    <= next_pc;
                     state_q <= fetch_gnt ? f_wait : f_req;
                  end
               end
            end
            default: state_q <= f_stop;
         endcase
      end
   end

   // Instruction register
   always_ff @(posedge clk) begin
      if (state_q == f_wait && fetch_rvalid) begin
         ir_q <= rdata;
      end
   end

endmodule

// File: source/raw_scoreboard.sv
`timescale 1ns/1ps
// One pending bit per register. Set wins over clear in the same cycle

module raw_scoreboard import core_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               set_valid,
   input  logic [reg_w_c-1:0] set_reg,
   input  wb_t                wb,
   input  logic [reg_w_c-1:0] src_a,
   input  logic [reg_w_c-1:0] src_b,
   input  logic               src_a_used,
   input  logic               src_b_used,
   output logic               hazard
);

   logic [7:0] pending_q;
   logic [7:0] set_vec;
   logic [7:0] clr_vec;
   logic       busy_a;
   logic       busy_b;

   // Decode set and clear masks
   assign set_vec = set_valid ? (8'b1 << set_reg) : 8'b0;
   assign clr_vec = wb.valid ? (8'b1 << wb.rd) : 8'b0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending_q <= '0;
      end else begin
         pending_q <= (pending_q & ~clr_vec) | set_vec;
      end
   end

   // A source being written back this cycle is already safe
   assign busy_a = pending_q[src_a] & ~clr_vec[src_a];
   assign busy_b = pending_q[src_b] & ~clr_vec[src_b];
   assign hazard = (src_a_used & busy_a) | (src_b_used & busy_b);

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ps
// Eight registers, two async read ports with writeback bypass, one write port

module reg_file import core_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [reg_w_c-1:0] rs_a,
   input  logic [reg_w_c-1:0] rs_b,
   output logic [xlen_c-1:0]  rd_a,
   output logic [xlen_c-1:0]  rd_b,
   input  wb_t                wb
);

   logic [xlen_c-1:0] regs_q [8];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regs_q <= '{default: '0};
      end else if (wb.valid) begin
         regs_q[wb.rd] <= wb.data;
      end
   end

   // Bypass so data arrives in the cycle its hazard clears
   assign rd_a = (wb.valid && wb.rd == rs_a) ? wb.data : regs_q[rs_a];
   assign rd_b = (wb.valid && wb.rd == rs_b) ? wb.data : regs_q[rs_b];

endmodule

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
// Fixed priority host > data > fetch, grants are combinational on request valid
// Only one read response can be in flight, since memory latency is one cycle

module mem_arbiter import core_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t host_req,
   input  mem_req_t data_req,
   input  mem_req_t fetch_req,
   output logic     host_gnt,
   output logic     data_gnt,
   output logic     fetch_gnt,
   output mem_req_t mem_req,
   output logic     host_rvalid,
   output logic     data_rvalid,
   output logic     fetch_rvalid
);

   // One-hot owner of last cycle's read: {host, data, fetch}
   logic [2:0] rd_sel_q;

   // Priority chain
   assign host_gnt  = host_req.valid;
   assign data_gnt  = data_req.valid & ~host_req.valid;
   assign fetch_gnt = fetch_req.valid & ~host_req.valid & ~data_req.valid;

   // Winner drives memory, idle otherwise
   always_comb begin
      mem_req = '0;
      if (host_gnt) begin
         mem_req = host_req;
      end else if (data_gnt) begin
         mem_req = data_req;
      end else if (fetch_gnt) begin
         mem_req = fetch_req;
      end
   end

   // Remember who read, response comes back next cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_sel_q <= '0;
      end else begin
         rd_sel_q <= {host_gnt, data_gnt, fetch_gnt} & {3{~mem_req.we}};
      end
   end

   assign host_rvalid  = rd_sel_q[2];
   assign data_rvalid  = rd_sel_q[1];
   assign fetch_rvalid = rd_sel_q[0];

endmodule

// File: source/unified_mem.sv
`timescale 1ns/1ps
// Single port, one-cycle read latency. rdata holds its value between reads
// Contents are not initialised, the host loader fills them

module unified_mem import core_pkg::*; #(
   parameter int mem_words_p = mem_words_c
) (
   input  logic              clk,
   input  mem_req_t          req,
   output logic [xlen_c-1:0] rdata
);

   // Storage array
   logic [xlen_c-1:0] mem [mem_words_p];

   always_ff @(posedge clk) begin
      if (req.valid) begin
         if (req.we) begin
            // Write, read port keeps old data
            mem[req.addr] <= req.wdata;
         end else begin
            // Registered read, data valid next cycle
            rdata <= mem[req.addr];
         end
      end
   end

endmodule

// File: source/core_pkg.sv
// Shared types of the 16-bit core. Word-addressed memory of 256 words, 8 registers
// Memory requests carry an 8-bit word address, so only 256 words are reachable

package core_pkg;

   // Datapath and memory geometry
   localparam int xlen_c      = 16;
   localparam int mem_words_c = 256;
   localparam int addr_w_c    = 8;
   localparam int reg_w_c     = 3;

   //////////////////////////////////////////////////
   // Instruction set
   //////////////////////////////////////////////////

   // Opcode lives in instruction bits 15:12
   typedef enum logic [3:0] {
      op_halt = 4'd0,
      op_nop  = 4'd1,
      op_addi = 4'd2,
      op_add  = 4'd3,
      op_ld   = 4'd4,
      op_st   = 4'd5,
      op_beqz = 4'd6,
      op_j    = 4'd7
   } opcode_e;

   // Decoded packet, fetch to execute
   typedef struct packed {
      opcode_e             opcode;
      logic [reg_w_c-1:0]  rd;
      logic [xlen_c-1:0]   op_a;   // rs value
      logic [xlen_c-1:0]   op_b;   // rt value, or store data
      logic [xlen_c-1:0]   imm;    // sign-extended
   } issue_pkt_t;

   //////////////////////////////////////////////////
   // Memory and writeback
   //////////////////////////////////////////////////

   // Requester holds valid until its grant
   typedef struct packed {
      logic                valid;
      logic                we;
      logic [addr_w_c-1:0] addr;
      logic [xlen_c-1:0]   wdata;
   } mem_req_t;

   // One register write per cycle
   typedef struct packed {
      logic                valid;
      logic [reg_w_c-1:0]  rd;
      logic [xlen_c-1:0]   data;
   } wb_t;

endpackage
